// ==== core_bus_pkg.sv ====
`default_nettype none

package core_bus_pkg;

  localparam int ADDR_W = 32; // Byte address width on both sides

  // Request as the core presents it, held with req until gnt
  typedef struct packed {
    logic              we;    // 1 = store
    logic [3:0]        be;    // Byte enables, bit 0 is the low byte
    logic [ADDR_W-1:0] addr;  // Byte address
    logic [31:0]       wdata;
  } core_cmd_t;

  // Response pulses back to the core
  typedef struct packed {
    logic        gnt;    // One-cycle grant
    logic        rvalid; // Only on reads, same cycle as gnt
    logic [31:0] rdata;
  } core_rsp_t;

  // Classic Wishbone master side
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [3:0]        sel;
    logic [ADDR_W-1:0] adr;
    logic [31:0]       dat; // Write data
  } wb_req_t;

  // Wishbone slave response
  typedef struct packed {
    logic        ack; // Single-cycle pulse
    logic [31:0] dat; // Read data, valid with ack
  } wb_rsp_t;

endpackage

`default_nettype wire

// ==== core_wb_bridge.sv ====
`default_nettype none

module core_wb_bridge import core_bus_pkg::*; #(
  parameter bit READ_ONLY = 1'b0 // Instruction side when set
) (
  input  wire logic      clk_core,
  input  wire logic      arst_n_i,
  input  wire logic      req_i,
  input  wire core_cmd_t cmd_i,
  output core_rsp_t      rsp_o,
  output wb_req_t        wb_o,
  input  wire wb_rsp_t   wb_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS,
    ST_REPLY
  } state_t;

  state_t state_q;

  logic              cyc_q;
  logic              we_q;
  logic [3:0]        sel_q;
  logic [ADDR_W-1:0] adr_q;
  logic [31:0]       dat_q;
  logic              gnt_q;
  logic              rvalid_q;
  logic [31:0]       rdata_q;

  logic take_req;  // Accept a new core command
  logic bus_done;  // Slave acknowledged our cycle

  assign take_req = (state_q == ST_IDLE) && req_i;
  assign bus_done = (state_q == ST_BUS) && wb_i.ack;

  // Handshake FSM
  always_ff @(posedge clk_core or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= ST_IDLE;
      cyc_q    <= 1'b0;
      gnt_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      gnt_q    <= 1'b0; // Pulses by default
      rvalid_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (req_i) begin
            cyc_q   <= 1'b1;
            state_q <= ST_BUS;
          end
        end
        ST_BUS: begin
          if (wb_i.ack) begin
            cyc_q    <= 1'b0; // Release the bus right away
            gnt_q    <= 1'b1;
            rvalid_q <= ~we_q;
            state_q  <= ST_REPLY;
          end
        end
        ST_REPLY: state_q <= ST_IDLE; // gnt is out this cycle
        default:  state_q <= ST_IDLE;
      endcase
    end
  end

  // Command and read data registers
  always_ff @(posedge clk_core) begin
    if (take_req) begin
      we_q  <= READ_ONLY ? 1'b0 : cmd_i.we;
      sel_q <= READ_ONLY ? 4'hf : cmd_i.be;
      adr_q <= cmd_i.addr;
      dat_q <= READ_ONLY ? 32'h0 : cmd_i.wdata;
    end
    if (bus_done) begin
      rdata_q <= wb_i.dat;
    end
  end

  assign wb_o.cyc = cyc_q;
  assign wb_o.stb = cyc_q; // One transfer per cycle
  assign wb_o.we  = we_q;
  assign wb_o.sel = sel_q;
  assign wb_o.adr = adr_q;
  assign wb_o.dat = dat_q;

  assign rsp_o.gnt    = gnt_q;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

endmodule

`default_nettype wire

// ==== wb_rr_arbiter.sv ====
`default_nettype none

module wb_rr_arbiter import core_bus_pkg::*; (
  input  wire logic    clk_core,
  input  wire logic    arst_n_i,
  input  wire wb_req_t m0_i,
  input  wire wb_req_t m1_i,
  output wb_rsp_t      m0_o,
  output wb_rsp_t      m1_o,
  output wb_req_t      s_o,
  input  wire wb_rsp_t s_i
);

  logic locked_q; // A master owns the slave
  logic owner_q;  // 0 = m0, 1 = m1
  logic last_q;   // Master served most recently

  logic pick;     // Round-robin choice while unlocked
  logic sel;      // Master routed to the slave this cycle
  logic m0_own;
  logic m1_own;

  // Fair choice between two requesters
  always_comb begin
    if (m0_i.cyc && m1_i.cyc) begin
      pick = ~last_q;
    end else begin
      pick = m1_i.cyc; // Falls back to m0 when nobody asks
    end
    sel = locked_q ? owner_q : pick;
  end

  always_ff @(posedge clk_core or negedge arst_n_i) begin
    if (!arst_n_i) begin
      locked_q <= 1'b0;
      owner_q  <= 1'b0;
      last_q   <= 1'b1; // So m0 wins the first tie
    end else if (!locked_q) begin
      if (m0_i.cyc || m1_i.cyc) begin
        locked_q <= 1'b1;
        owner_q  <= pick;
      end
    end else if (s_i.ack) begin
      locked_q <= 1'b0; // Cycle ends with the ack
      last_q   <= owner_q;
    end
  end

  // Request mux toward the slave
  always_comb begin
    if (sel) begin
      s_o = m1_i;
    end else begin
      s_o = m0_i;
    end
  end

  assign m0_own = locked_q && !owner_q;
  assign m1_own = locked_q && owner_q;

  // Response goes only to the owner
  assign m0_o.ack = s_i.ack && m0_own;
  assign m0_o.dat = m0_own ? s_i.dat : 32'h0;
  assign m1_o.ack = s_i.ack && m1_own;
  assign m1_o.dat = m1_own ? s_i.dat : 32'h0;

endmodule

`default_nettype wire

// ==== wb_ram.sv ====
`default_nettype none

module wb_ram import core_bus_pkg::*; #(
  parameter int MEM_WORDS = 1024
) (
  input  wire logic    clk_core,
  input  wire logic    arst_n_i,
  input  wire wb_req_t wb_i,
  output wb_rsp_t      wb_o
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [31:0] mem [MEM_WORDS];

  logic [ADDR_W-3:0] word_addr;
  logic [IDX_W-1:0]  idx;
  logic              access;  // New strobe, not yet acknowledged
  logic              ack_q;
  logic [31:0]       rdata_q;

  assign word_addr = wb_i.adr[ADDR_W-1:2];
  assign idx       = IDX_W'(word_addr % MEM_WORDS); // Wraps at the RAM size

  // ack_q blocks a second access while the pulse is out
  assign access = wb_i.cyc && wb_i.stb && !ack_q;

  always_ff @(posedge clk_core or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access; // Low again the cycle after a pulse
    end
  end

  // Byte-lane writes
  always_ff @(posedge clk_core) begin
    if (access && wb_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (wb_i.sel[b]) begin
          mem[idx][8*b +: 8] <= wb_i.dat[8*b +: 8];
        end
      end
    end
  end

  // Read data lines up with ack
  always_ff @(posedge clk_core) begin
    if (access && !wb_i.we) begin
      rdata_q <= mem[idx];
    end
  end

  assign wb_o.ack = ack_q;
  assign wb_o.dat = rdata_q;

endmodule

`default_nettype wire

// ==== core_bus_top.sv ====
`default_nettype none

module core_bus_top import core_bus_pkg::*; #(
  parameter int MEM_WORDS = 1024
) (
  input  wire logic      clk_core,
  input  wire logic      arst_n_i,
  input  wire logic      instr_req_i,
  input  wire core_cmd_t instr_cmd_i,
  output core_rsp_t      instr_rsp_o,
  input  wire logic      data_req_i,
  input  wire core_cmd_t data_cmd_i,
  output core_rsp_t      data_rsp_o
);

  wb_req_t instr_wb_req;
  wb_rsp_t instr_wb_rsp;
  wb_req_t data_wb_req;
  wb_rsp_t data_wb_rsp;
  wb_req_t ram_wb_req;
  wb_rsp_t ram_wb_rsp;

  // Fetch port, never writes
  core_wb_bridge #(
    .READ_ONLY (1'b1)
  ) u_instr_bridge (
    .clk_core (clk_core),
    .arst_n_i (arst_n_i),
    .req_i    (instr_req_i),
    .cmd_i    (instr_cmd_i),
    .rsp_o    (instr_rsp_o),
    .wb_o     (instr_wb_req),
    .wb_i     (instr_wb_rsp)
  );

  core_wb_bridge #(
    .READ_ONLY (1'b0)
  ) u_data_bridge (
    .clk_core (clk_core),
    .arst_n_i (arst_n_i),
    .req_i    (data_req_i),
    .cmd_i    (data_cmd_i),
    .rsp_o    (data_rsp_o),
    .wb_o     (data_wb_req),
    .wb_i     (data_wb_rsp)
  );

  // Data side is master 0 and wins the first tie
  wb_rr_arbiter u_arbiter (
    .clk_core (clk_core),
    .arst_n_i (arst_n_i),
    .m0_i     (data_wb_req),
    .m1_i     (instr_wb_req),
    .m0_o     (data_wb_rsp),
    .m1_o     (instr_wb_rsp),
    .s_o      (ram_wb_req),
    .s_i      (ram_wb_rsp)
  );

  wb_ram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_ram (
    .clk_core (clk_core),
    .arst_n_i (arst_n_i),
    .wb_i     (ram_wb_req),
    .wb_o     (ram_wb_rsp)
  );

endmodule

`default_nettype wire

// ==== core_bus_chk.sv ====
`default_nettype none

module core_bus_chk import core_bus_pkg::*; (
  input wire logic      clk_core,
  input wire logic      arst_n_i,
  input wire logic      instr_req_i,
  input wire core_rsp_t instr_rsp_i,
  input wire logic      data_req_i,
  input wire core_cmd_t data_cmd_i,
  input wire core_rsp_t data_rsp_i,
  input wire wb_rsp_t   m0_rsp_i,
  input wire wb_rsp_t   m1_rsp_i,
  input wire wb_req_t   ram_req_i,
  input wire wb_rsp_t   ram_rsp_i
);

  // A grant answers a request that is still held
  instr_gnt_held: assert property (@(posedge clk_core) disable iff (!arst_n_i)
    instr_rsp_i.gnt |-> instr_req_i)
    else $error("instr gnt while req is low");

  data_gnt_held: assert property (@(posedge clk_core) disable iff (!arst_n_i)
    data_rsp_i.gnt |-> data_req_i)
    else $error("data gnt while req is low");

  one_owner_ack: assert property (@(posedge clk_core) disable iff (!arst_n_i)
    !(m0_rsp_i.ack && m1_rsp_i.ack))
    else $error("arbiter acked both masters");

  ram_ack_stb: assert property (@(posedge clk_core) disable iff (!arst_n_i)
    ram_rsp_i.ack |-> ram_req_i.stb)
    else $error("RAM ack without stb");

  // Stores complete with gnt alone
  no_rvalid_write: assert property (@(posedge clk_core) disable iff (!arst_n_i)
    data_rsp_i.rvalid |-> !data_cmd_i.we)
    else $error("data rvalid on a write");

endmodule

bind core_bus_top core_bus_chk u_chk (
  .clk_core    (clk_core),
  .arst_n_i    (arst_n_i),
  .instr_req_i (instr_req_i),
  .instr_rsp_i (instr_rsp_o),
  .data_req_i  (data_req_i),
  .data_cmd_i  (data_cmd_i),
  .data_rsp_i  (data_rsp_o),
  .m0_rsp_i    (data_wb_rsp),
  .m1_rsp_i    (instr_wb_rsp),
  .ram_req_i   (ram_wb_req),
  .ram_rsp_i   (ram_wb_rsp)
);

`default_nettype wire

// ==== tb_core_bus.sv ====
`default_nettype none

module tb_core_bus import core_bus_pkg::*; ();

  localparam int MEM_WORDS  = 1024;
  localparam int MAX_CYCLES = 4000; // About 200 accesses at 8 cycles worst case, plus margin

  logic      clk_core;
  logic      arst_n;
  logic      instr_req;
  core_cmd_t instr_cmd;
  core_rsp_t instr_rsp;
  logic      data_req;
  core_cmd_t data_cmd;
  core_rsp_t data_rsp;

  logic [31:0] ref_mem [MEM_WORDS]; // Mirror of the RAM contents
  logic [31:0] written_q [$];       // Addresses the model knows
  logic [31:0] rng_state = 32'd48;
  int          err_cnt    = 0;
  int          cycle_cnt  = 0;
  int          data_gnts  = 0;
  int          instr_gnts = 0;

  core_bus_top #(
    .MEM_WORDS (MEM_WORDS)
  ) dut_i (
    .clk_core    (clk_core),
    .arst_n_i    (arst_n),
    .instr_req_i (instr_req),
    .instr_cmd_i (instr_cmd),
    .instr_rsp_o (instr_rsp),
    .data_req_i  (data_req),
    .data_cmd_i  (data_cmd),
    .data_rsp_o  (data_rsp)
  );

  always #10 clk_core = ~clk_core;

  // Grant counters and the run limit
  always @(posedge clk_core) begin
    cycle_cnt++;
    if (data_rsp.gnt) data_gnts++;
    if (instr_rsp.gnt) instr_gnts++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles (%0d errors so far)",
               MAX_CYCLES, err_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Word slot after wrapping at the RAM size
  function automatic int word_index(input logic [31:0] addr);
    return int'((addr >> 2) % 32'(MEM_WORDS));
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic report_error(input string msg);
    err_cnt++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  // One core access, started and finished on a falling edge
  task automatic run_access(input bit instr, input logic we, input logic [3:0] be,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            output core_rsp_t rsp, output int lat);
    core_cmd_t cmd;
    int        other_start;
    int        waited;
    cmd.we      = we;
    cmd.be      = be;
    cmd.addr    = addr;
    cmd.wdata   = wdata;
    lat         = 0;
    other_start = instr ? data_gnts : instr_gnts;
    if (instr) begin
      instr_cmd = cmd;
      instr_req = 1'b1;
    end else begin
      data_cmd = cmd;
      data_req = 1'b1;
    end
    do begin
      @(negedge clk_core);
      lat++;
      rsp = instr ? instr_rsp : data_rsp;
    end while (!rsp.gnt);
    waited = (instr ? data_gnts : instr_gnts) - other_start;
    if (waited > 2) report_error($sformatf("port waited for %0d foreign grants", waited));
    @(negedge clk_core);
    if (instr) begin
      instr_req = 1'b0;
      if (instr_rsp.gnt) report_error("instr gnt longer than one cycle");
    end else begin
      data_req = 1'b0;
      if (data_rsp.gnt) report_error("data gnt longer than one cycle");
    end
  endtask

  task automatic data_write(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, input bit solo);
    core_rsp_t rsp;
    int        lat;
    int        idx;
    run_access(1'b0, 1'b1, be, addr, wdata, rsp, lat);
    idx = word_index(addr);
    ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, be);
    if (rsp.rvalid) report_error($sformatf("rvalid on write to %h", addr));
    if (solo && lat != 3) report_error($sformatf("write latency %0d, expected 3", lat));
  endtask

  task automatic data_read(input logic [31:0] addr, input bit solo, output logic [31:0] rdata);
    core_rsp_t rsp;
    int        lat;
    run_access(1'b0, 1'b0, 4'hf, addr, 32'h0, rsp, lat);
    rdata = rsp.rdata;
    if (!rsp.rvalid) report_error($sformatf("no rvalid on read of %h", addr));
    if (rsp.rdata !== ref_mem[word_index(addr)])
      report_error($sformatf("read %h got %h, expected %h", addr, rsp.rdata,
                             ref_mem[word_index(addr)]));
    if (solo && lat != 3) report_error($sformatf("read latency %0d, expected 3", lat));
  endtask

  task automatic instr_fetch(input logic [31:0] addr, input bit solo, output logic [31:0] rdata);
    core_rsp_t rsp;
    int        lat;
    run_access(1'b1, 1'b0, 4'hf, addr, 32'h0, rsp, lat);
    rdata = rsp.rdata;
    if (!rsp.rvalid) report_error($sformatf("no rvalid on fetch of %h", addr));
    if (rsp.rdata !== ref_mem[word_index(addr)])
      report_error($sformatf("fetch %h got %h, expected %h", addr, rsp.rdata,
                             ref_mem[word_index(addr)]));
    if (solo && lat != 3) report_error($sformatf("fetch latency %0d, expected 3", lat));
  endtask

  task automatic test_idle();
    repeat (10) begin
      @(negedge clk_core);
      if (instr_rsp.gnt || instr_rsp.rvalid || data_rsp.gnt || data_rsp.rvalid)
        report_error("response pulse while no request is made");
    end
  endtask

  task automatic test_write_read();
    logic [31:0] addr;
    logic [31:0] rd;
    for (int i = 0; i < 32; i++) begin
      addr = next_rand() & ~32'h3;
      data_write(addr, next_rand(), 4'hf, 1'b1);
      written_q.push_back(addr);
    end
    foreach (written_q[i]) data_read(written_q[i], 1'b1, rd);
  endtask

  task automatic test_byte_enables();
    logic [31:0] r;
    logic [31:0] rd;
    for (int i = 0; i < 8; i++) begin
      data_write(written_q[i], next_rand(), 4'hf, 1'b1); // Known base word
      r = next_rand();
      data_write(written_q[i], next_rand(), r[19:16], 1'b1);
      data_read(written_q[i], 1'b1, rd);
    end
  endtask

  task automatic test_fetch();
    logic [31:0] rd;
    for (int i = 0; i < 16; i++) instr_fetch(written_q[i*2], 1'b1, rd);
  endtask

  task automatic test_contention();
    logic [31:0] iaddr;
    logic [31:0] daddr;
    logic [31:0] wdata;
    logic [31:0] ird;
    logic [31:0] drd;
    for (int k = 0; k < 24; k++) begin
      iaddr = written_q[k % 32];
      if (k % 2 == 0) begin
        daddr = next_rand() & ~32'h3;
        wdata = next_rand();
        // Keep the store off the fetched word
        if (word_index(daddr) == word_index(iaddr)) daddr = daddr + 32'd4;
        fork
          data_write(daddr, wdata, 4'hf, 1'b0);
          instr_fetch(iaddr, 1'b0, ird);
        join
      end else begin
        fork
          begin
            // Back-to-back loads while one fetch waits
            for (int j = 0; j < 3; j++) begin
              daddr = written_q[(k + 5 + j) % 32];
              data_read(daddr, 1'b0, drd);
            end
          end
          instr_fetch(iaddr, 1'b0, ird);
        join
      end
    end
  endtask

  task automatic test_wrap();
    logic [31:0] off;
    logic [31:0] wdata;
    logic [31:0] rd;
    for (int k = 1; k <= 4; k++) begin
      off   = (next_rand() % 32'(MEM_WORDS * 4)) & ~32'h3;
      wdata = next_rand();
      data_write(off + 32'(MEM_WORDS * 4 * k), wdata, 4'hf, 1'b1);
      data_read(off, 1'b1, rd);
      if (rd !== wdata) report_error($sformatf("wrap store %0d missed offset %h", k, off));
      instr_fetch(off + 32'(MEM_WORDS * 4 * (k + 2)), 1'b1, rd);
      if (rd !== wdata) report_error($sformatf("wrap fetch missed offset %h", off));
    end
  endtask

  initial begin
    clk_core  = 1'b0;
    arst_n    = 1'b0;
    instr_req = 1'b0;
    instr_cmd = '0;
    data_req  = 1'b0;
    data_cmd  = '0;
    repeat (8) @(posedge clk_core);
    @(negedge clk_core);
    arst_n = 1'b1;

    test_idle();
    test_write_read();
    test_byte_enables();
    test_fetch();
    test_contention();
    test_wrap();

    $display("Checks done: %0d errors in %0d cycles", err_cnt, cycle_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
core_bus_pkg.sv
core_wb_bridge.sv
wb_rr_arbiter.sv
wb_ram.sv
core_bus_top.sv
core_bus_chk.sv
tb_core_bus.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; pass only if the testbench prints its pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_core_bus -f list.f -o tb_core_bus_sim &&
./obj_dir/tb_core_bus_sim | tee /dev/stderr | grep -qx "Test OK" &&
echo "PASS" || { echo "FAIL"; exit 1; }
